// File: common/soc_pkg.sv
package soc_pkg;

  // --------------------------------------------------
  // Bus widths and transfer structs
  // --------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned BeWidth   = DataWidth / 8;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [DataWidth-1:0] wdata;
    logic [BeWidth-1:0]   be;
  } bus_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------
  typedef enum logic [1:0] {
    TgtRom,
    TgtSpm,
    TgtTimer,
    TgtNone
  } target_e;

  typedef struct packed {
    target_e              tgt;
    logic [AddrWidth-1:0] start_addr;
    logic [AddrWidth-1:0] length;
  } addr_rule_t;

  localparam int unsigned NumRules = 3;

  // Half-open ranges, start inclusive
  localparam addr_rule_t AddrMap [NumRules] = '{
    '{tgt: TgtRom,   start_addr: 32'h0000_1000, length: 32'h0000_1000},
    '{tgt: TgtTimer, start_addr: 32'h0200_0000, length: 32'h0001_0000},
    '{tgt: TgtSpm,   start_addr: 32'h8000_0000, length: 32'h0001_0000}
  };

  // --------------------------------------------------
  // Target constants
  // --------------------------------------------------
  localparam int unsigned RomWords = 16;
  localparam logic [31:0] RomSeed  = 32'hB007_0000;

  localparam logic [AddrWidth-1:0] TimerMsipOff = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] TimerCmpOff  = 32'h0000_4000;
  localparam logic [AddrWidth-1:0] TimerTimeOff = 32'h0000_BFF8;

endpackage

// File: rtl/soc_xbar.sv
`timescale 1ns/1ps

module soc_xbar
  import soc_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Master side
  input  logic                 req_valid_i,
  input  bus_req_t             req_i,
  output logic                 rsp_valid_o,
  output bus_rsp_t             rsp_o,
  // Target side
  output logic                 rom_sel_o,
  output logic                 spm_sel_o,
  output logic                 tmr_sel_o,
  output bus_req_t             req_o,
  input  logic [DataWidth-1:0] rom_rdata_i,
  input  logic [DataWidth-1:0] spm_rdata_i,
  input  logic [DataWidth-1:0] tmr_rdata_i
);

  target_e              tgt_d, tgt_q;
  logic [AddrWidth-1:0] offset;
  logic                 valid_q;

  // --------------------------------------------------
  // Request decode
  // --------------------------------------------------
  always_comb begin
    tgt_d  = TgtNone;
    offset = '0;
    for (int unsigned i = 0; i < NumRules; i++) begin
      // Subtract first so start + length never has to be formed
      if ((req_i.addr >= AddrMap[i].start_addr) &&
          ((req_i.addr - AddrMap[i].start_addr) < AddrMap[i].length)) begin
        tgt_d  = AddrMap[i].tgt;
        offset = req_i.addr - AddrMap[i].start_addr;
      end
    end
  end

  assign rom_sel_o = req_valid_i && (tgt_d == TgtRom);
  assign spm_sel_o = req_valid_i && (tgt_d == TgtSpm);
  assign tmr_sel_o = req_valid_i && (tgt_d == TgtTimer);

  // Targets see a region-relative address
  always_comb begin
    req_o      = req_i;
    req_o.addr = offset;
  end

  // --------------------------------------------------
  // Response path
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      tgt_q   <= TgtNone;
    end else begin
      valid_q <= req_valid_i;
      tgt_q   <= tgt_d;
    end
  end

  assign rsp_valid_o = valid_q;

  always_comb begin
    rsp_o = '0;
    case (tgt_q)
      TgtRom:   rsp_o.rdata = rom_rdata_i;
      TgtSpm:   rsp_o.rdata = spm_rdata_i;
      TgtTimer: rsp_o.rdata = tmr_rdata_i;
      // Unmapped, decode error with zero data
      default:  rsp_o.err   = 1'b1;
    endcase
  end

endmodule

// File: rtl/bootrom.sv
`timescale 1ns/1ps

module bootrom
  import soc_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 sel_i,
  input  bus_req_t             req_i,
  output logic [DataWidth-1:0] rdata_o
);

  localparam int unsigned RomIdxW = $clog2(RomWords);

  logic [DataWidth-1:0] rom_table [RomWords];
  logic [AddrWidth-4:0] word_idx;
  logic [DataWidth-1:0] rdata_q;

  // Seed plus index on top, its inverse below
  function automatic logic [DataWidth-1:0] rom_entry(int unsigned idx);
    logic [31:0] word;
    word = RomSeed + idx;
    return {word, ~word};
  endfunction

  for (genvar i = 0; i < RomWords; i++) begin : gen_table
    assign rom_table[i] = rom_entry(i);
  end

  assign word_idx = req_i.addr[AddrWidth-1:3];

  // Writes and out-of-table reads return zero
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (!req_i.we && (word_idx < RomWords)) begin
        rdata_q <= rom_table[word_idx[RomIdxW-1:0]];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: rtl/spm_ram.sv
`timescale 1ns/1ps

module spm_ram
  import soc_pkg::*;
#(
  parameter int unsigned NumWords = 8192
) (
  input  logic                 clk_i,
  input  logic                 sel_i,
  input  bus_req_t             req_i,
  output logic [DataWidth-1:0] rdata_o
);

  // Power-of-two depth, index wraps by slicing
  localparam int unsigned IdxW = (NumWords > 1) ? $clog2(NumWords) : 1;

  logic [DataWidth-1:0] mem [NumWords];
  logic [IdxW-1:0]      idx;
  logic [DataWidth-1:0] rdata_q;

  assign idx = req_i.addr[3 +: IdxW];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (req_i.we) begin
        for (int unsigned b = 0; b < BeWidth; b++) begin
          if (req_i.be[b]) begin
            mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
        // Write acknowledge carries no data
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: clint/clint_timer.sv
`timescale 1ns/1ps

module clint_timer
  import soc_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rtc_i,
  input  logic                 sel_i,
  input  bus_req_t             req_i,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 timer_irq_o,
  output logic                 ipi_o
);

  logic [2:0]           rtc_q;
  logic                 rtc_rise;
  logic [DataWidth-1:0] mtime_q;
  logic [DataWidth-1:0] mtimecmp_q;
  logic                 msip_q;
  logic                 timer_irq_q;
  logic [DataWidth-1:0] rdata_q;
  logic                 wr_en;

  // --------------------------------------------------
  // RTC synchronizer and edge detect
  // --------------------------------------------------
  // Stages 0 and 1 synchronize, stage 2 holds the previous level
  assign rtc_rise = rtc_q[1] && !rtc_q[2];
  assign wr_en    = sel_i && req_i.we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q <= '0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
    end
  end

  // --------------------------------------------------
  // Timer registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
    end else begin
      if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && (req_i.addr == TimerCmpOff)) begin
        for (int unsigned b = 0; b < BeWidth; b++) begin
          if (req_i.be[b]) begin
            mtimecmp_q[b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
      end
      if (wr_en && (req_i.addr == TimerMsipOff) && req_i.be[0]) begin
        msip_q <= req_i.wdata[0];
      end
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // Register read port
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (req_i.we) begin
        rdata_q <= '0;
      end else begin
        case (req_i.addr)
          TimerMsipOff: rdata_q <= {{(DataWidth-1){1'b0}}, msip_q};
          TimerCmpOff:  rdata_q <= mtimecmp_q;
          TimerTimeOff: rdata_q <= mtime_q;
          default:      rdata_q <= '0;
        endcase
      end
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

endmodule

// File: rtl/debug_req_gate.sv
`timescale 1ns/1ps

module debug_req_gate #(
  parameter int unsigned DbgDelayCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CntW = (DbgDelayCycles > 0) ? $clog2(DbgDelayCycles + 1) : 1;

  logic [CntW-1:0] cnt_q;
  logic            open;

  // Boot code runs undisturbed until the count expires
  assign open = (cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntW'(DbgDelayCycles);
    end else if (!open) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = open ? debug_req_i : 1'b0;

endmodule

// File: rtl/soc_subsystem.sv
`timescale 1ns/1ps

module soc_subsystem
  import soc_pkg::*;
#(
  parameter int unsigned SpmWords       = 8192,
  parameter int unsigned DbgDelayCycles = 500
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     rtc_i,
  input  logic     req_valid_i,
  input  bus_req_t req_i,
  output logic     rsp_valid_o,
  output bus_rsp_t rsp_o,
  input  logic     debug_req_i,
  output logic     debug_req_o,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  logic                 rom_sel, spm_sel, tmr_sel;
  bus_req_t             tgt_req;
  logic [DataWidth-1:0] rom_rdata, spm_rdata, tmr_rdata;

  // --------------------------------------------------
  // Fabric
  // --------------------------------------------------
  soc_xbar i_xbar (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .rom_sel_o   ( rom_sel     ),
    .spm_sel_o   ( spm_sel     ),
    .tmr_sel_o   ( tmr_sel     ),
    .req_o       ( tgt_req     ),
    .rom_rdata_i ( rom_rdata   ),
    .spm_rdata_i ( spm_rdata   ),
    .tmr_rdata_i ( tmr_rdata   )
  );

  // --------------------------------------------------
  // Targets
  // --------------------------------------------------
  bootrom i_bootrom (
    .clk_i   ( clk_i     ),
    .sel_i   ( rom_sel   ),
    .req_i   ( tgt_req   ),
    .rdata_o ( rom_rdata )
  );

  spm_ram #(
    .NumWords ( SpmWords )
  ) i_spm (
    .clk_i   ( clk_i     ),
    .sel_i   ( spm_sel   ),
    .req_i   ( tgt_req   ),
    .rdata_o ( spm_rdata )
  );

  clint_timer i_clint (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .sel_i       ( tmr_sel     ),
    .req_i       ( tgt_req     ),
    .rdata_o     ( tmr_rdata   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // Debug request window
  debug_req_gate #(
    .DbgDelayCycles ( DbgDelayCycles )
  ) i_dbg_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: testbench/tb_soc_subsystem.sv
`timescale 1ns/1ps

module tb_soc_subsystem
  import soc_pkg::*;
();

  localparam int unsigned SpmWords = 64;
  localparam int unsigned DbgDelay = 20;
  localparam int unsigned RtcEdges = 7;

  logic     clk_i;
  logic     rst_ni;
  logic     rtc_i;
  logic     req_valid_i;
  bus_req_t req_i;
  logic     rsp_valid_o;
  bus_rsp_t rsp_o;
  logic     debug_req_i;
  logic     debug_req_o;
  logic     timer_irq_o;
  logic     ipi_o;

  // Stimulus table, one request per entry
  string    names[$];
  bus_req_t reqs[$];
  bus_rsp_t exps[$];
  bit       built;

  logic [31:0] rng_state = 32'hf4160437;
  logic [63:0] spm_model [SpmWords];
  int          end_mem, end_cmp, end_time, end_cmp2, end_set, end_clr;

  soc_subsystem #(
    .SpmWords       ( SpmWords ),
    .DbgDelayCycles ( DbgDelay )
  ) dut0 (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Reference helpers
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [63:0] next_word();
    logic [31:0] hi;
    rng_state = xorshift32(rng_state);
    hi = rng_state;
    rng_state = xorshift32(rng_state);
    return {hi, rng_state};
  endfunction

  // Seed plus index on top, inverted copy below
  function automatic logic [63:0] rom_word(input int unsigned idx);
    logic [31:0] w;
    w = RomSeed + idx;
    return {w, ~w};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
                                              input logic [7:0] be);
    logic [63:0] res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected rdata=%h err=%b actual rdata=%h err=%b",
               name, exp.rdata, exp.err, act.rdata, act.err);
      $display("SOME TESTS FAILED");
      $fatal(1, "Response mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (exp !== act) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "Output mismatch");
    end
  endtask

  task automatic add(input string name, input logic we, input logic [31:0] addr,
                     input logic [63:0] wdata, input logic [7:0] be,
                     input logic [63:0] rdata, input logic err);
    bus_req_t r;
    bus_rsp_t e;
    r.addr  = addr;
    r.we    = we;
    r.wdata = wdata;
    r.be    = be;
    e.rdata = rdata;
    e.err   = err;
    names.push_back(name);
    reqs.push_back(r);
    exps.push_back(e);
  endtask

  task automatic spm_write(input int w, input logic [63:0] data, input logic [7:0] be);
    spm_model[w] = merge_bytes(spm_model[w], data, be);
    add($sformatf("spm wr %0d be %h", w, be), 1'b1, 32'h8000_0000 + w * 8, data, be, '0, 1'b0);
  endtask

  task automatic spm_read(input int w);
    add($sformatf("spm rd %0d", w), 1'b0, 32'h8000_0000 + w * 8, '0, '0, spm_model[w], 1'b0);
  endtask

  task automatic build_table();
    logic [7:0] mixed_be [4];
    logic [31:0] bad_addr [3];
    mixed_be = '{8'h0F, 8'hA5, 8'h3C, 8'h80};
    bad_addr = '{32'h0000_0000, 32'h0300_0000, 32'h4000_0000};
    foreach (mixed_be[k]) begin
      add($sformatf("rom rd %0d", k * 5), 1'b0, 32'h1000 + k * 40, '0, '0, rom_word(k * 5), 1'b0);
    end
    add("rom rd 20", 1'b0, 32'h1000 + 20 * 8, '0, '0, '0, 1'b0);
    add("rom wr 3", 1'b1, 32'h1000 + 3 * 8, 64'hdead_beef, 8'hFF, '0, 1'b0);
    add("rom rd 3 after wr", 1'b0, 32'h1000 + 3 * 8, '0, '0, rom_word(3), 1'b0);
    for (int w = 0; w < 5; w++) spm_write(w, next_word(), 8'hFF);
    for (int w = 0; w < 5; w++) spm_read(w);
    // Partial write directly followed by its read
    foreach (mixed_be[k]) begin
      spm_write(k, next_word(), mixed_be[k]);
      spm_read(k);
    end
    foreach (bad_addr[k]) begin
      add($sformatf("unmapped rd %h", bad_addr[k]), 1'b0, bad_addr[k], '0, '0, '0, 1'b1);
      add($sformatf("unmapped wr %h", bad_addr[k]), 1'b1, bad_addr[k], next_word(), 8'hFF,
          '0, 1'b1);
    end
    end_mem = names.size() - 1;
    add("mtimecmp wr 5", 1'b1, 32'h0200_0000 + TimerCmpOff, 64'd5, 8'hFF, '0, 1'b0);
    add("mtimecmp rd", 1'b0, 32'h0200_0000 + TimerCmpOff, '0, '0, 64'd5, 1'b0);
    end_cmp = names.size() - 1;
    add("mtime rd", 1'b0, 32'h0200_0000 + TimerTimeOff, '0, '0, 64'd7, 1'b0);
    end_time = names.size() - 1;
    add("mtimecmp wr 100", 1'b1, 32'h0200_0000 + TimerCmpOff, 64'd100, 8'hFF, '0, 1'b0);
    end_cmp2 = names.size() - 1;
    add("msip wr 1", 1'b1, 32'h0200_0000 + TimerMsipOff, 64'd1, 8'h01, '0, 1'b0);
    add("msip rd 1", 1'b0, 32'h0200_0000 + TimerMsipOff, '0, '0, 64'd1, 1'b0);
    end_set = names.size() - 1;
    add("msip wr 0", 1'b1, 32'h0200_0000 + TimerMsipOff, 64'd0, 8'h01, '0, 1'b0);
    add("msip rd 0", 1'b0, 32'h0200_0000 + TimerMsipOff, '0, '0, 64'd0, 1'b0);
    end_clr = names.size() - 1;
  endtask

  // Back-to-back requests, each response checked one cycle later
  task automatic run_range(input int lo, input int hi);
    for (int i = lo; i <= hi + 1; i++) begin
      @(posedge clk_i);
      req_valid_i <= (i <= hi);
      req_i       <= (i <= hi) ? reqs[i] : '0;
      @(negedge clk_i);
      if (i > lo) begin
        check_bit({names[i-1], " valid"}, rsp_valid_o, 1'b1);
        check_rsp(names[i-1], exps[i-1], rsp_o);
      end
    end
  endtask

  task automatic rtc_edges(input int n);
    for (int k = 0; k < n; k++) begin
      @(posedge clk_i);
      rtc_i <= 1'b1;
      repeat (4) @(posedge clk_i);
      rtc_i <= 1'b0;
      repeat (3) @(posedge clk_i);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    rst_ni      = 1'b0;
    rtc_i       = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    debug_req_i = 1'b1;
    build_table();
    built = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Gate closed for DbgDelay cycles after release, bus idle meanwhile
    for (int k = 0; k < DbgDelay + 4; k++) begin
      @(negedge clk_i);
      check_bit($sformatf("debug gate cycle %0d", k), debug_req_o, k >= DbgDelay);
      check_bit($sformatf("idle valid cycle %0d", k), rsp_valid_o, 1'b0);
    end
    run_range(0, end_mem);
    run_range(end_mem + 1, end_cmp);
    check_bit("irq before rtc", timer_irq_o, 1'b0);
    rtc_edges(RtcEdges);
    run_range(end_cmp + 1, end_time);
    check_bit("irq after rtc", timer_irq_o, 1'b1);
    run_range(end_time + 1, end_cmp2);
    @(negedge clk_i);
    check_bit("irq after cmp 100", timer_irq_o, 1'b0);
    run_range(end_cmp2 + 1, end_set);
    check_bit("ipi set", ipi_o, 1'b1);
    run_range(end_set + 1, end_clr);
    check_bit("ipi clear", ipi_o, 1'b0);
    check_bit("debug still open", debug_req_o, 1'b1);
    $display("ALL TESTS PASSED");
    $finish;
  end

  // Watchdog sized from table length, gate delay and rtc toggles
  initial begin
    longint unsigned limit;
    wait (built);
    limit = 20 * (4 * names.size() + DbgDelay + 4 * 2 * RtcEdges + 100);
    #(limit);
    $display("Timeout: the run did not finish within %0d ns", limit);
    $display("SOME TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: project.f
common/soc_pkg.sv
rtl/soc_xbar.sv
rtl/bootrom.sv
rtl/spm_ram.sv
clint/clint_timer.sv
rtl/debug_req_gate.sv
rtl/soc_subsystem.sv
testbench/tb_soc_subsystem.sv
